//--- rtl/ptw_pkg.sv
/*
 * sv39 page table walker shared definitions
 * address widths, walk level codes and the pte word with its field view
 */

package ptw_pkg;

  // --------------------------------------------------------------------------
  // address widths
  // --------------------------------------------------------------------------
  localparam int unsigned PLEN       = 56;
  localparam int unsigned VLEN       = 39;
  localparam int unsigned PPN_W      = 44;
  localparam int unsigned VPN_SEG_W  = 9;
  localparam int unsigned PAGE_OFF_W = 12;
  localparam int unsigned PTE_W      = 64;

  // --------------------------------------------------------------------------
  // walk levels, first level maps 1G and the last maps 4K
  // --------------------------------------------------------------------------
  localparam int unsigned LVL_W = 2;

  localparam logic [LVL_W-1:0] LVL_1G = 2'd0;
  localparam logic [LVL_W-1:0] LVL_2M = 2'd1;
  localparam logic [LVL_W-1:0] LVL_4K = 2'd2;

  // one pte word, seen either as the memory word or as sv39 fields
  typedef union packed {
    logic [PTE_W-1:0] raw;
    struct packed {
      // must be zero, checked on every level
      logic [9:0]       reserved;
      logic [PPN_W-1:0] ppn;
      // free for software
      logic [1:0]       rsw;
      logic             d;
      logic             a;
      logic             g;
      logic             u;
      logic             x;
      logic             w;
      logic             r;
      logic             v;
    } pte;
  } pte_word_u;

endpackage

//--- rtl/ptw_miss_select.sv
/*
 * tlb miss selection
 * picks a data or instruction miss while the walker is idle and
 * forms the first level pte pointer from satp
 */

`timescale 1ns/1ps

module ptw_miss_select
  import ptw_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              idle_i,
  input  logic              enable_translation_i,
  input  logic              en_ld_st_translation_i,
  input  logic              itlb_access_i,
  input  logic              itlb_hit_i,
  input  logic [VLEN-1:0]   itlb_vaddr_i,
  input  logic              dtlb_access_i,
  input  logic              dtlb_hit_i,
  input  logic [VLEN-1:0]   dtlb_vaddr_i,
  input  logic [PPN_W-1:0]  satp_ppn_i,
  output logic              miss_valid_o,
  output logic              miss_is_instr_o,
  output logic [VLEN-1:0]   miss_vaddr_o,
  output logic [PLEN-1:0]   miss_pptr_o,
  output logic              itlb_miss_o,
  output logic              dtlb_miss_o
);

  logic i_miss;
  logic d_miss;

  // a miss counts only with translation on for that side
  assign i_miss = enable_translation_i & itlb_access_i & ~itlb_hit_i;
  assign d_miss = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;

  // data side wins, instruction miss stays pending at the itlb
  assign dtlb_miss_o  = idle_i & d_miss;
  assign itlb_miss_o  = idle_i & i_miss & ~d_miss;
  assign miss_valid_o = itlb_miss_o | dtlb_miss_o;

  assign miss_is_instr_o = ~d_miss;
  assign miss_vaddr_o    = d_miss ? dtlb_vaddr_i : itlb_vaddr_i;

  // root table base plus vpn[2], eight bytes per pte
  assign miss_pptr_o = {satp_ppn_i, miss_vaddr_o[VLEN-1 -: VPN_SEG_W], 3'b000};

  // a taken miss moves the walker out of idle so the pulse lasts one cycle
  a_miss_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_valid_o |=> !miss_valid_o);

endmodule

//--- rtl/ptw_pte_buffer.sv
/*
 * pte response buffer
 * registers the memory response and classifies the pte word
 */

`timescale 1ns/1ps

module ptw_pte_buffer
  import ptw_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             mem_rvalid_i,
  input  logic [PTE_W-1:0] mem_rdata_i,
  output logic             pte_valid_o,
  output pte_word_u        pte_o,
  output logic             pte_invalid_o,
  output logic             pte_leaf_o,
  output logic             pte_nonleaf_bad_o
);

  logic      rvalid_q;
  pte_word_u pte_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem_rvalid_i;
    end
  end

  // data word only captured with its valid
  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i) begin
      pte_q.raw <= mem_rdata_i;
    end
  end

  assign pte_valid_o = rvalid_q;
  assign pte_o       = pte_q;

  // --------------------------------------------------------------------------
  // classification
  // --------------------------------------------------------------------------
  // not valid, write without read, or reserved bits in use
  assign pte_invalid_o = ~pte_q.pte.v | (pte_q.pte.w & ~pte_q.pte.r) |
                         (|pte_q.pte.reserved);

  // any of r or x marks a leaf, else pointer to next table
  assign pte_leaf_o = pte_q.pte.r | pte_q.pte.x;

  // a, d and u are reserved on pointers
  assign pte_nonleaf_bad_o = pte_q.pte.a | pte_q.pte.d | pte_q.pte.u;

endmodule

//--- rtl/ptw_leaf_check.sv
/*
 * leaf pte checker
 * access permissions for fetch, load and store and the
 * alignment of 1G and 2M superpages
 */

`timescale 1ns/1ps

module ptw_leaf_check
  import ptw_pkg::*;
(
  input  pte_word_u        pte_i,
  input  logic [LVL_W-1:0] level_i,
  input  logic             is_instr_i,
  input  logic             is_store_i,
  input  logic             mxr_i,
  output logic             leaf_fault_o
);

  logic perm_fault;
  logic align_fault;

  // --------------------------------------------------------------------------
  // permissions
  // --------------------------------------------------------------------------
  always_comb begin
    perm_fault = 1'b0;
    if (is_instr_i) begin
      // fetch needs execute, a is managed by software
      perm_fault = ~pte_i.pte.x | ~pte_i.pte.a;
    end else begin
      // load reads r, or x when mxr makes executable pages readable
      perm_fault = ~(pte_i.pte.a & (pte_i.pte.r | (pte_i.pte.x & mxr_i)));
      // store also wants write and an already dirty page
      if (is_store_i && (!pte_i.pte.w || !pte_i.pte.d)) begin
        perm_fault = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // superpage alignment
  // --------------------------------------------------------------------------
  always_comb begin
    align_fault = 1'b0;
    if (level_i == LVL_1G) begin
      // 1G leaf, ppn[1] and ppn[0] must be zero
      align_fault = |pte_i.pte.ppn[2*VPN_SEG_W-1:0];
    end else if (level_i == LVL_2M) begin
      // 2M leaf, only ppn[0]
      align_fault = |pte_i.pte.ppn[VPN_SEG_W-1:0];
    end
  end

  assign leaf_fault_o = perm_fault | align_fault;

endmodule

//--- rtl/ptw_walker.sv
/*
 * sv39 walk state machine
 * issues pte reads, follows pointers down three levels and ends
 * each walk with a tlb update or a page fault pulse
 */

`timescale 1ns/1ps

module ptw_walker
  import ptw_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       miss_valid_i,
  input  logic                       miss_is_instr_i,
  input  logic [VLEN-1:0]            miss_vaddr_i,
  input  logic [PLEN-1:0]            miss_pptr_i,
  input  logic                       mem_gnt_i,
  input  logic                       pte_valid_i,
  input  pte_word_u                  pte_i,
  input  logic                       pte_invalid_i,
  input  logic                       pte_leaf_i,
  input  logic                       pte_nonleaf_bad_i,
  input  logic                       leaf_fault_i,
  output logic                       idle_o,
  output logic [LVL_W-1:0]           level_o,
  output logic                       is_instr_o,
  output logic                       mem_req_o,
  output logic [PLEN-1:0]            mem_addr_o,
  output logic                       mem_tag_valid_o,
  output logic                       itlb_update_valid_o,
  output logic                       dtlb_update_valid_o,
  output logic [VLEN-PAGE_OFF_W-1:0] update_vpn_o,
  output logic                       update_is_2m_o,
  output logic                       update_is_1g_o,
  output pte_word_u                  update_pte_o,
  output logic [VLEN-1:0]            update_vaddr_o,
  output logic                       ptw_active_o,
  output logic                       walking_instr_o,
  output logic                       ptw_error_o
);

  enum logic [2:0] {IDLE, WAIT_GRANT, LOOKUP, ERROR, WAIT_RVALID} state_q, state_d;

  logic [LVL_W-1:0]     lvl_q, lvl_d;
  logic [PLEN-1:0]      pptr_q, pptr_d;
  logic [VLEN-1:0]      vaddr_q, vaddr_d;
  logic                 is_instr_q, is_instr_d;
  logic                 global_q, global_d;
  logic                 tag_valid_q, tag_valid_d;
  logic [VPN_SEG_W-1:0] next_seg;

  // no new walk is taken while a flush is up
  assign idle_o          = (state_q == IDLE) & ~flush_i;
  assign ptw_active_o    = (state_q != IDLE);
  assign level_o         = lvl_q;
  assign is_instr_o      = is_instr_q;
  assign walking_instr_o = is_instr_q;
  assign mem_addr_o      = pptr_q;
  assign mem_tag_valid_o = tag_valid_q;

  // --------------------------------------------------------------------------
  // tlb update contents
  // --------------------------------------------------------------------------
  assign update_vaddr_o = vaddr_q;
  assign update_vpn_o   = vaddr_q[VLEN-1:PAGE_OFF_W];
  assign update_is_1g_o = (lvl_q == LVL_1G);
  assign update_is_2m_o = (lvl_q == LVL_2M);

  always_comb begin
    update_pte_o       = pte_i;
    // a global pointer above makes the whole subtree global
    update_pte_o.pte.g = pte_i.pte.g | global_q;
  end

  // vpn[1] after the first level, vpn[0] after the second
  assign next_seg = (lvl_q == LVL_1G) ? vaddr_q[PAGE_OFF_W+2*VPN_SEG_W-1 -: VPN_SEG_W]
                                      : vaddr_q[PAGE_OFF_W+VPN_SEG_W-1 -: VPN_SEG_W];

  // --------------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d             = state_q;
    lvl_d               = lvl_q;
    pptr_d              = pptr_q;
    vaddr_d             = vaddr_q;
    is_instr_d          = is_instr_q;
    global_d            = global_q;
    tag_valid_d         = 1'b0;
    mem_req_o           = 1'b0;
    itlb_update_valid_o = 1'b0;
    dtlb_update_valid_o = 1'b0;
    ptw_error_o         = 1'b0;

    case (state_q)
      IDLE: begin
        // every walk starts at the root with no global seen
        lvl_d    = LVL_1G;
        global_d = 1'b0;
        if (miss_valid_i) begin
          pptr_d     = miss_pptr_i;
          vaddr_d    = miss_vaddr_i;
          is_instr_d = miss_is_instr_i;
          state_d    = WAIT_GRANT;
        end
      end
      WAIT_GRANT: begin
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          // tag goes out the cycle after the grant
          tag_valid_d = 1'b1;
          state_d     = LOOKUP;
        end
      end
      LOOKUP: begin
        if (pte_valid_i) begin
          if (pte_i.pte.g) begin
            global_d = 1'b1;
          end
          if (pte_invalid_i) begin
            state_d = ERROR;
          end else if (pte_leaf_i) begin
            if (leaf_fault_i) begin
              state_d = ERROR;
            end else begin
              itlb_update_valid_o = is_instr_q;
              dtlb_update_valid_o = ~is_instr_q;
              state_d             = IDLE;
            end
          end else if (lvl_q == LVL_4K || pte_nonleaf_bad_i) begin
            // pointer past the last level, or a/d/u on a pointer
            state_d = ERROR;
          end else begin
            lvl_d   = lvl_q + LVL_W'(1);
            pptr_d  = {pte_i.pte.ppn, next_seg, 3'b000};
            state_d = WAIT_GRANT;
          end
        end
      end
      ERROR: begin
        ptw_error_o = 1'b1;
        state_d     = IDLE;
      end
      WAIT_RVALID: begin
        // drop the response owed from before the flush
        if (pte_valid_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // flush ends the walk quietly, a granted read still has to come back
    if (flush_i) begin
      itlb_update_valid_o = 1'b0;
      dtlb_update_valid_o = 1'b0;
      ptw_error_o         = 1'b0;
      if ((state_q == LOOKUP && !pte_valid_i) || (state_q == WAIT_GRANT && mem_gnt_i)) begin
        state_d = WAIT_RVALID;
      end else begin
        state_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      lvl_q       <= LVL_1G;
      is_instr_q  <= 1'b0;
      global_q    <= 1'b0;
      tag_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      lvl_q       <= lvl_d;
      is_instr_q  <= is_instr_d;
      global_q    <= global_d;
      tag_valid_q <= tag_valid_d;
    end
  end

  // walk pointer and address
  always_ff @(posedge clk_i) begin
    pptr_q  <= pptr_d;
    vaddr_q <= vaddr_d;
  end

  // --------------------------------------------------------------------------
  // assertions
  // --------------------------------------------------------------------------
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i && !flush_i |=> mem_req_o && $stable(mem_addr_o));

  // a flush leaves no update or error pulse behind it
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !(itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o));

  // every update or fault pulse ends the walk
  a_end_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o) |=> !ptw_active_o);

endmodule

//--- rtl/ptw_top.sv
/*
 * sv39 page table walker top level
 * miss selection, pte response buffer, walk state machine
 * and leaf permission check
 */

`timescale 1ns/1ps

module ptw_top
  import ptw_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       enable_translation_i,
  input  logic                       en_ld_st_translation_i,
  input  logic                       lsu_is_store_i,
  input  logic                       mxr_i,
  input  logic [PPN_W-1:0]           satp_ppn_i,
  // tlb lookups
  input  logic                       itlb_access_i,
  input  logic                       itlb_hit_i,
  input  logic [VLEN-1:0]            itlb_vaddr_i,
  input  logic                       dtlb_access_i,
  input  logic                       dtlb_hit_i,
  input  logic [VLEN-1:0]            dtlb_vaddr_i,
  // memory port
  output logic                       mem_req_o,
  output logic [PLEN-1:0]            mem_addr_o,
  input  logic                       mem_gnt_i,
  output logic                       mem_tag_valid_o,
  input  logic                       mem_rvalid_i,
  input  logic [PTE_W-1:0]           mem_rdata_i,
  // tlb updates and status
  output logic                       itlb_miss_o,
  output logic                       dtlb_miss_o,
  output logic                       itlb_update_valid_o,
  output logic                       dtlb_update_valid_o,
  output logic [VLEN-PAGE_OFF_W-1:0] update_vpn_o,
  output logic                       update_is_2m_o,
  output logic                       update_is_1g_o,
  output pte_word_u                  update_pte_o,
  output logic [VLEN-1:0]            update_vaddr_o,
  output logic                       ptw_active_o,
  output logic                       walking_instr_o,
  output logic                       ptw_error_o
);

  logic             idle;
  logic             miss_valid;
  logic             miss_is_instr;
  logic [VLEN-1:0]  miss_vaddr;
  logic [PLEN-1:0]  miss_pptr;
  logic             pte_valid;
  pte_word_u        pte;
  logic             pte_invalid;
  logic             pte_leaf;
  logic             pte_nonleaf_bad;
  logic [LVL_W-1:0] level;
  logic             is_instr;
  logic             leaf_fault;

  ptw_miss_select u_miss_select (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .idle_i                 (idle),
    .enable_translation_i   (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .satp_ppn_i             (satp_ppn_i),
    .miss_valid_o           (miss_valid),
    .miss_is_instr_o        (miss_is_instr),
    .miss_vaddr_o           (miss_vaddr),
    .miss_pptr_o            (miss_pptr),
    .itlb_miss_o            (itlb_miss_o),
    .dtlb_miss_o            (dtlb_miss_o)
  );

  ptw_pte_buffer u_pte_buffer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .mem_rvalid_i      (mem_rvalid_i),
    .mem_rdata_i       (mem_rdata_i),
    .pte_valid_o       (pte_valid),
    .pte_o             (pte),
    .pte_invalid_o     (pte_invalid),
    .pte_leaf_o        (pte_leaf),
    .pte_nonleaf_bad_o (pte_nonleaf_bad)
  );

  // judges the buffered pte against the walk in progress
  ptw_leaf_check u_leaf_check (
    .pte_i        (pte),
    .level_i      (level),
    .is_instr_i   (is_instr),
    .is_store_i   (lsu_is_store_i),
    .mxr_i        (mxr_i),
    .leaf_fault_o (leaf_fault)
  );

  ptw_walker u_walker (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .miss_valid_i        (miss_valid),
    .miss_is_instr_i     (miss_is_instr),
    .miss_vaddr_i        (miss_vaddr),
    .miss_pptr_i         (miss_pptr),
    .mem_gnt_i           (mem_gnt_i),
    .pte_valid_i         (pte_valid),
    .pte_i               (pte),
    .pte_invalid_i       (pte_invalid),
    .pte_leaf_i          (pte_leaf),
    .pte_nonleaf_bad_i   (pte_nonleaf_bad),
    .leaf_fault_i        (leaf_fault),
    .idle_o              (idle),
    .level_o             (level),
    .is_instr_o          (is_instr),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o),
    .mem_tag_valid_o     (mem_tag_valid_o),
    .itlb_update_valid_o (itlb_update_valid_o),
    .dtlb_update_valid_o (dtlb_update_valid_o),
    .update_vpn_o        (update_vpn_o),
    .update_is_2m_o      (update_is_2m_o),
    .update_is_1g_o      (update_is_1g_o),
    .update_pte_o        (update_pte_o),
    .update_vaddr_o      (update_vaddr_o),
    .ptw_active_o        (ptw_active_o),
    .walking_instr_o     (walking_instr_o),
    .ptw_error_o         (ptw_error_o)
  );

endmodule

//--- testbench/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 4 ns clock, active low reset held for 8 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- testbench/tb_ptw.sv
/*
 * sv39 page table walker testbench
 * memory model with random grant and response delays, reference walk,
 * directed and random walks, flush cases and a watchdog
 */

`timescale 1ns/1ps

module tb_ptw;

  localparam int          N_RANDOM = 48;
  localparam int          N_WALKS  = N_RANDOM + 20;
  localparam logic [43:0] SATP_PPN = 44'h100;

  logic clk, rst_n;
  logic flush_i, enable_translation_i, en_ld_st_translation_i, lsu_is_store_i, mxr_i;
  logic [43:0] satp_ppn_i;
  logic itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i;
  logic [38:0] itlb_vaddr_i, dtlb_vaddr_i;
  logic mem_req_o, mem_gnt_i, mem_tag_valid_o, mem_rvalid_i;
  logic [55:0] mem_addr_o;
  logic [63:0] mem_rdata_i;
  logic itlb_miss_o, dtlb_miss_o, itlb_update_valid_o, dtlb_update_valid_o;
  logic [26:0] update_vpn_o;
  logic update_is_2m_o, update_is_1g_o, ptw_active_o, walking_instr_o, ptw_error_o;
  logic [38:0] update_vaddr_o;
  ptw_pkg::pte_word_u update_pte_o;

  // page table memory and the pte reads the reference expects
  logic [63:0] mem [logic [55:0]];
  logic [55:0] exp_addrs [$];
  bit          addr_check, exp_pending, exp_fault, exp_instr;
  bit          mem_busy;
  logic [63:0] exp_pte;
  logic [26:0] exp_vpn;
  logic [38:0] exp_va;
  int          exp_lvl;
  integer      seed = 21;
  int          tbl_id = 0;

  tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  ptw_top u_dut (.*, .clk_i(clk), .rst_ni(rst_n));

  task automatic stop_run(input string what);
    $display("%0t: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run("value check failed");
    end
  endtask

  function automatic logic [63:0] make_pte(input logic [43:0] ppn, input logic [7:0] flags);
    return {10'b0, ppn, 2'b00, flags};
  endfunction

  // --------------------------------------------------------------------------
  // reference walk by the sv39 rules
  // --------------------------------------------------------------------------
  function automatic void ref_walk(input logic [38:0] va, input bit instr, input bit store,
                                   input bit mxr_v, output bit fault, output logic [63:0] pte,
                                   output int lvl);
    logic [55:0] ptr;
    logic [63:0] w;
    logic [43:0] ppn;
    bit          glob;
    ptr   = {SATP_PPN, va[38:30], 3'b000};
    glob  = 1'b0;
    fault = 1'b1;
    pte   = '0;
    lvl   = 0;
    for (int l = 0; l < 3; l++) begin
      exp_addrs.push_back(ptr);
      w   = mem.exists(ptr) ? mem[ptr] : 64'd0;
      ppn = w[53:10];
      lvl = l;
      if (w[5]) glob = 1'b1;
      // v, w without r, reserved bits
      if (!w[0] || (w[2] && !w[1]) || w[63:54] != 10'd0) return;
      if (w[1] || w[3]) begin
        if (instr) fault = !w[3] || !w[6];
        else fault = !(w[6] && (w[1] || (w[3] && mxr_v))) || (store && (!w[2] || !w[7]));
        if (l == 0 && ppn[17:0] != 18'd0) fault = 1'b1;
        if (l == 1 && ppn[8:0] != 9'd0) fault = 1'b1;
        pte    = w;
        pte[5] = w[5] | glob;
        return;
      end
      // pointer past the last level, or a, d, u on a pointer
      if (l == 2 || w[6] || w[7] || w[4]) return;
      ptr = {ppn, (l == 0) ? va[29:21] : va[20:12], 3'b000};
    end
  endfunction

  // fresh tables per call, leaf at the given level
  task automatic build_tables(input logic [38:0] va, input int leaf_lvl, input logic [63:0] leaf,
                              input logic [7:0] f0, input logic [7:0] f1);
    logic [43:0] t1;
    logic [43:0] t2;
    t1     = 44'h1000 + 44'(tbl_id * 2);
    t2     = t1 + 44'd1;
    tbl_id = tbl_id + 1;
    mem[{SATP_PPN, va[38:30], 3'b000}] = (leaf_lvl == 0) ? leaf : make_pte(t1, f0);
    if (leaf_lvl >= 1) mem[{t1, va[29:21], 3'b000}] = (leaf_lvl == 1) ? leaf : make_pte(t2, f1);
    if (leaf_lvl == 2) mem[{t2, va[20:12], 3'b000}] = leaf;
  endtask

  function automatic logic [7:0] rand_ptr_flags();
    case ($unsigned($random(seed)) % 6)
      0: return 8'h21;
      1: return 8'h41;
      2: return 8'h11;
      3: return 8'($random(seed));
      default: return 8'h01;
    endcase
  endfunction

  task automatic expect_walk(input bit instr, input logic [38:0] va, input bit store,
                             input bit mxr_v);
    bit          f;
    logic [63:0] p;
    int          l;
    exp_addrs.delete();
    ref_walk(va, instr, store, mxr_v, f, p, l);
    exp_fault   = f;
    exp_pte     = p;
    exp_lvl     = l;
    exp_instr   = instr;
    exp_va      = va;
    exp_vpn     = va[38:12];
    addr_check  = 1'b1;
    exp_pending = 1'b1;
  endtask

  task automatic finish_walk();
    while (exp_pending) @(negedge clk);
    check_equal("pte reads left", 64'(exp_addrs.size()), 64'd0);
    @(negedge clk);
    check_equal("ptw_active_o", 64'(ptw_active_o), 64'd0);
  endtask

  task automatic run_walk(input bit instr, input logic [38:0] va, input bit store,
                          input bit mxr_v);
    expect_walk(instr, va, store, mxr_v);
    @(negedge clk);
    lsu_is_store_i = store;
    mxr_i          = mxr_v;
    if (instr) begin
      itlb_access_i = 1'b1;
      itlb_vaddr_i  = va;
    end else begin
      dtlb_access_i = 1'b1;
      dtlb_vaddr_i  = va;
    end
    @(posedge clk);
    check_equal("itlb_miss_o", 64'(itlb_miss_o), 64'(instr));
    check_equal("dtlb_miss_o", 64'(dtlb_miss_o), 64'(!instr));
    @(negedge clk);
    itlb_access_i = 1'b0;
    dtlb_access_i = 1'b0;
    finish_walk();
  endtask

  // flush while waiting for the grant or for the response
  task automatic flush_walk(input logic [38:0] va, input bit in_lookup);
    addr_check  = 1'b0;
    exp_pending = 1'b0;
    @(negedge clk);
    dtlb_access_i = 1'b1;
    dtlb_vaddr_i  = va;
    @(negedge clk);
    dtlb_access_i = 1'b0;
    if (in_lookup) while (!mem_tag_valid_o) @(negedge clk);
    else while (!mem_req_o) @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    // walker idle and memory model done before the next walk
    while (ptw_active_o || mem_busy) @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // memory model, grant after 0 to 3 cycles, data 1 to 4 cycles later
  // --------------------------------------------------------------------------
  initial begin : mem_model
    int          d;
    logic [55:0] addr;
    forever begin
      @(negedge clk);
      if (mem_req_o) begin
        mem_busy = 1'b1;
        d = $unsigned($random(seed)) % 4;
        repeat (d) @(negedge clk);
        if (mem_req_o) begin
          addr = mem_addr_o;
          if (addr_check) begin
            if (exp_addrs.size() == 0) stop_run("pte read beyond the expected walk");
            check_equal("mem_addr_o", 64'(addr), 64'(exp_addrs.pop_front()));
            check_equal("walking_instr_o", 64'(walking_instr_o), 64'(exp_instr));
          end
          mem_gnt_i = 1'b1;
          @(negedge clk);
          mem_gnt_i = 1'b0;
          check_equal("mem_tag_valid_o", 64'(mem_tag_valid_o), 64'd1);
          d = $unsigned($random(seed)) % 4;
          repeat (d) @(negedge clk);
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem.exists(addr) ? mem[addr] : 64'd0;
          @(negedge clk);
          mem_rvalid_i = 1'b0;
        end
        mem_busy = 1'b0;
      end
    end
  end

  // compare every update or error pulse with the reference
  always @(posedge clk) begin
    if (rst_n && (itlb_update_valid_o || dtlb_update_valid_o || ptw_error_o)) begin
      if (!exp_pending) stop_run("update or error pulse with no walk pending");
      check_equal("ptw_error_o", 64'(ptw_error_o), 64'(exp_fault));
      if (!exp_fault) begin
        check_equal("itlb_update_valid_o", 64'(itlb_update_valid_o), 64'(exp_instr));
        check_equal("dtlb_update_valid_o", 64'(dtlb_update_valid_o), 64'(!exp_instr));
        check_equal("update_pte_o", update_pte_o.raw, exp_pte);
        check_equal("update_vpn_o", 64'(update_vpn_o), 64'(exp_vpn));
        check_equal("update_vaddr_o", 64'(update_vaddr_o), 64'(exp_va));
        check_equal("update_is_1g_o", 64'(update_is_1g_o), 64'(exp_lvl == 0));
        check_equal("update_is_2m_o", 64'(update_is_2m_o), 64'(exp_lvl == 1));
      end
      exp_pending = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (N_WALKS * 200) @(posedge clk);
    stop_run("watchdog expired before all walks finished");
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    logic [38:0] va;
    logic [7:0]  flags;
    logic [43:0] ppn;
    logic [63:0] leaf;
    int          lvl;
    flush_i = 1'b0;
    enable_translation_i = 1'b1;
    en_ld_st_translation_i = 1'b1;
    lsu_is_store_i = 1'b0;
    mxr_i = 1'b0;
    satp_ppn_i = SATP_PPN;
    itlb_access_i = 1'b0;
    itlb_hit_i = 1'b0;
    itlb_vaddr_i = '0;
    dtlb_access_i = 1'b0;
    dtlb_hit_i = 1'b0;
    dtlb_vaddr_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    addr_check = 1'b0;
    exp_pending = 1'b0;
    wait (rst_n);
    @(negedge clk);
    check_equal("outputs after reset", 64'({mem_req_o, mem_tag_valid_o, itlb_update_valid_o,
                dtlb_update_valid_o, ptw_error_o, itlb_miss_o, dtlb_miss_o, ptw_active_o}), 64'd0);

    // 4K walks for fetch, load and store
    build_tables(39'h12_3456_7000, 2, make_pte(44'h0ABCDE, 8'hCF), 8'h01, 8'h01);
    run_walk(1'b1, 39'h12_3456_7000, 1'b0, 1'b0);
    run_walk(1'b0, 39'h12_3456_7000, 1'b0, 1'b0);
    run_walk(1'b0, 39'h12_3456_7000, 1'b1, 1'b0);
    // superpages, aligned then misaligned
    build_tables(39'h40_8000_0000, 0, make_pte(44'h40000, 8'hCF), 8'h01, 8'h01);
    run_walk(1'b0, 39'h40_8000_0000, 1'b0, 1'b0);
    build_tables(39'h21_0020_0000, 1, make_pte(44'h3200, 8'hCF), 8'h01, 8'h01);
    run_walk(1'b1, 39'h21_0020_0000, 1'b0, 1'b0);
    build_tables(39'h40_8000_0000, 0, make_pte(44'h40001, 8'hCF), 8'h01, 8'h01);
    run_walk(1'b0, 39'h40_8000_0000, 1'b0, 1'b0);
    build_tables(39'h21_0020_0000, 1, make_pte(44'h3201, 8'hCF), 8'h01, 8'h01);
    run_walk(1'b0, 39'h21_0020_0000, 1'b0, 1'b0);
    // execute-only page read with and without mxr, store to clean page
    build_tables(39'h33_0000_5000, 2, make_pte(44'h777, 8'h49), 8'h01, 8'h01);
    run_walk(1'b0, 39'h33_0000_5000, 1'b0, 1'b1);
    run_walk(1'b0, 39'h33_0000_5000, 1'b0, 1'b0);
    build_tables(39'h33_0000_6000, 2, make_pte(44'h778, 8'h47), 8'h01, 8'h01);
    run_walk(1'b0, 39'h33_0000_6000, 1'b1, 1'b0);
    // global bit on the root pointer
    build_tables(39'h55_5555_5000, 2, make_pte(44'h999, 8'hCF), 8'h21, 8'h01);
    run_walk(1'b1, 39'h55_5555_5000, 1'b0, 1'b0);

    // both sides miss together, data walk first
    build_tables(39'h11_1111_1000, 2, make_pte(44'h111, 8'hCF), 8'h01, 8'h01);
    build_tables(39'h66_6666_6000, 2, make_pte(44'h666, 8'hCF), 8'h01, 8'h01);
    expect_walk(1'b0, 39'h66_6666_6000, 1'b0, 1'b0);
    @(negedge clk);
    itlb_access_i = 1'b1;
    itlb_vaddr_i  = 39'h11_1111_1000;
    dtlb_access_i = 1'b1;
    dtlb_vaddr_i  = 39'h66_6666_6000;
    @(posedge clk);
    check_equal("dtlb_miss_o", 64'(dtlb_miss_o), 64'd1);
    check_equal("itlb_miss_o", 64'(itlb_miss_o), 64'd0);
    @(negedge clk);
    dtlb_access_i = 1'b0;
    while (exp_pending) @(negedge clk);
    // instruction miss is still presented and is taken next
    expect_walk(1'b1, 39'h11_1111_1000, 1'b0, 1'b0);
    while (exp_pending) @(negedge clk);
    itlb_access_i = 1'b0;
    finish_walk();

    // flushes, then a clean walk
    flush_walk(39'h12_3456_7000, 1'b0);
    flush_walk(39'h12_3456_7000, 1'b1);
    run_walk(1'b0, 39'h12_3456_7000, 1'b0, 1'b0);

    // ------------------------------------------------------------------------
    // random ptes over all fault rules
    // ------------------------------------------------------------------------
    for (int i = 0; i < N_RANDOM; i++) begin
      va    = 39'({$random(seed), $random(seed)});
      lvl   = $unsigned($random(seed)) % 3;
      flags = 8'($random(seed));
      if ($unsigned($random(seed)) % 8 != 0) flags[0] = 1'b1;
      ppn = 44'({$random(seed), $random(seed)});
      if ($random(seed) & 1) ppn[17:0] = '0;
      leaf = make_pte(ppn, flags);
      if ($unsigned($random(seed)) % 8 == 0) leaf[63] = 1'b1;
      build_tables(va, lvl, leaf, rand_ptr_flags(), rand_ptr_flags());
      run_walk(1'($random(seed)), va, 1'($random(seed)), 1'($random(seed)));
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- flist.f
rtl/ptw_pkg.sv
rtl/ptw_miss_select.sv
rtl/ptw_pte_buffer.sv
rtl/ptw_leaf_check.sv
rtl/ptw_walker.sv
rtl/ptw_top.sv
testbench/tb_clock_gen.sv
testbench/tb_ptw.sv

//--- run.sh
#!/bin/sh
# build and run the page table walker testbench with verilator
verilator --binary --timing --assert -f flist.f --top-module tb_ptw -o sim_ptw \
  > build.log 2>&1 &&
./obj_dir/sim_ptw > sim.log 2>&1 ||
{ echo "build or simulation failed"; cat build.log sim.log; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" ||
{ cat sim.log; exit 1; }
